/* Makefile */
# Verilator simulation of the memory access unit

VERILATOR ?= verilator
TOP       ?= tb_mem_unit
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Simulation finished: PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* hw/mem_addr_gen.sv */
//****************************************************************************
// address selection, ea register, cached read address and request decision
//****************************************************************************
`timescale 1ns/1ps

module mem_addr_gen #(
    parameter int ADDR_W = 24
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 cen,
    input  mem_pkg::ea_sel_t     ea_sel,
    input  mem_pkg::acc_size_t   size,
    input  mem_pkg::fetch_mode_t fetch_mode,
    input  logic                 wr,
    input  logic                 inc_pc,
    input  logic                 da2ea,
    input  logic [31:0]          da,
    input  logic [ADDR_W-1:0]    pc,
    input  logic [31:0]          xsp,
    input  logic [31:0]          md,
    input  logic                 seq_active,
    output mem_pkg::mem_req_t    req,
    output logic                 start,
    output logic [31:0]          ea,
    output logic                 pending
);

    logic [ADDR_W-1:0] nx_addr;
    logic [ADDR_W-1:0] ca;        // cached read address
    logic              wr_l;      // wr at the last idle cen edge
    logic              pc_ok;
    logic              write_req;
    logic              read_req;

    always_comb begin
        case (ea_sel)
            mem_pkg::ea_da:  nx_addr = da[ADDR_W-1:0];
            mem_pkg::ea_sp:  nx_addr = xsp[ADDR_W-1:0];
            mem_pkg::ea_mem: nx_addr = ea[ADDR_W-1:0];
            default:         nx_addr = pc;
        endcase
    end

    // pc reads wait for a stable pc
    assign pc_ok     = !inc_pc || ea_sel != mem_pkg::ea_pc;
    assign write_req = wr && !wr_l;
    assign read_req  = !wr && nx_addr != ca && pc_ok;
    assign pending   = write_req || read_req;
    assign start     = pending && !seq_active;

    always_comb begin
        req.addr     = 24'(nx_addr);
        req.size     = size;
        req.is_write = write_req;
        req.is_read  = read_req;
        req.wdata    = md;
        if (ea_sel == mem_pkg::ea_pc || fetch_mode == mem_pkg::fetch_long)
            req.read_len = 3'd4;  // pc fetches are always long
        else
            req.read_len = mem_pkg::size_bytes(size);
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ca   <= '1;
            wr_l <= 1'b0;
            ea   <= '0;
        end else if (cen) begin
            if (da2ea)
                ea <= da;
            if (!seq_active)
                wr_l <= wr;  // a rise during a busy access is caught later
            if (start)
                ca <= write_req ? '1 : nx_addr;  // writes drop the cached address
        end
    end

endmodule

/* hw/mem_bus_seq.sv */
//****************************************************************************
// bus beat sequencer for writes and reads, lane enables and data alignment
//****************************************************************************
`timescale 1ns/1ps

module mem_bus_seq #(
    parameter int ADDR_W = 24
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                cen,
    input  mem_pkg::mem_req_t   req,
    input  logic                start,
    input  logic                bus_busy,
    output logic [ADDR_W-1:0]   bus_addr,
    output logic [15:0]         bus_din,
    output logic [1:0]          bus_we,
    output logic                bus_rd,
    output mem_pkg::read_beat_t beat,
    output logic                seq_active
);

    typedef enum logic [1:0] {
        idle       = 2'd0,
        write_beat = 2'd1,
        read_beat  = 2'd2
    } state_t;

    state_t      state;
    logic [1:0]  lanes;        // byte lanes of the current beat
    logic [2:0]  left;         // bytes still to go after this beat
    logic [2:0]  taken;        // bytes moved by earlier beats
    logic        first;
    logic [23:0] wbuf;         // write bytes not yet on the bus
    logic [39:0] wd_align;
    logic [2:0]  req_len;
    logic [1:0]  start_lanes;
    logic [1:0]  next_lanes;
    logic        accept;
    logic        beat_done;

    function automatic logic [2:0] lane_cnt(logic [1:0] l);
        return (l == 2'b11) ? 3'd2 : 3'd1;
    endfunction

    assign accept    = cen && start && state == idle;
    assign beat_done = cen && !bus_busy && state != idle;

    assign req_len = req.is_write ? mem_pkg::size_bytes(req.size) : req.read_len;

    // odd start begins with the high lane only
    assign start_lanes = req.addr[0] ? 2'b10 : (req_len >= 3'd2 ? 2'b11 : 2'b01);
    assign next_lanes  = (left >= 3'd2) ? 2'b11 : 2'b01;  // later beats are even
    assign wd_align    = req.addr[0] ? {req.wdata, 8'h00} : {8'h00, req.wdata};

    assign seq_active = state != idle;
    assign bus_rd     = state == read_beat;
    assign bus_we     = (state == write_beat) ? lanes : 2'b00;

    always_comb begin
        beat.valid        = cen && !bus_busy && bus_rd;
        beat.first        = first;
        beat.dst_byte     = taken[1:0];
        beat.take_hi_only = lanes == 2'b10;
        beat.take_lo_only = lanes == 2'b01;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= idle;
            lanes    <= 2'b00;
            left     <= 3'd0;
            taken    <= 3'd0;
            first    <= 1'b0;
            bus_addr <= '0;
        end else if (accept) begin
            bus_addr <= ADDR_W'(req.addr);
            lanes    <= start_lanes;
            left     <= req_len - lane_cnt(start_lanes);
            taken    <= 3'd0;
            first    <= 1'b1;
            if (req.is_write)
                state <= write_beat;
            else if (req.is_read)
                state <= read_beat;
        end else if (beat_done) begin
            first <= 1'b0;
            taken <= taken + lane_cnt(lanes);
            if (left == 3'd0) begin
                state <= idle;  // last beat done
            end else begin
                bus_addr <= bus_addr + (bus_addr[0] ? ADDR_W'(1) : ADDR_W'(2));
                lanes    <= next_lanes;
                left     <= left - lane_cnt(next_lanes);
            end
        end
    end

    // write data shifts out 16 bits per beat
    always_ff @(posedge clk) begin
        if (accept && req.is_write) begin
            bus_din <= wd_align[15:0];
            wbuf    <= wd_align[39:16];
        end else if (beat_done && state == write_beat) begin
            bus_din <= wbuf[15:0];
            wbuf    <= wbuf >> 16;
        end
    end

    a_rd_we_excl: assert property (@(posedge clk) disable iff (rst)
        !(bus_rd && bus_we != 2'b00))
        else $error("bus_rd and bus_we active together");

    // a cycle held by bus_busy keeps its address and strobes
    a_bus_hold: assert property (@(posedge clk) disable iff (rst)
        seq_active && bus_busy |=> $stable(bus_addr) && $stable(bus_we) && $stable(bus_rd))
        else $error("bus cycle changed while bus_busy was high");

    a_start_idle: assert property (@(posedge clk) disable iff (rst)
        cen && start |-> !seq_active)
        else $error("start seen while an access is active");

endmodule

/* hw/mem_pkg.sv */
//****************************************************************************
// access enums, pipeline stage structs and the byte count helper
//****************************************************************************
package mem_pkg;

    // address source of an access
    typedef enum logic [1:0] {
        ea_pc  = 2'd0,
        ea_da  = 2'd1,
        ea_sp  = 2'd2,
        ea_mem = 2'd3
    } ea_sel_t;

    typedef enum logic [1:0] {
        size_byte = 2'd0,
        size_word = 2'd1,
        size_long = 2'd2
    } acc_size_t;

    typedef enum logic {
        fetch_long  = 1'b0,   // always 4 bytes
        fetch_sized = 1'b1    // only the access size
    } fetch_mode_t;

    // address generation to sequencer
    typedef struct packed {
        logic [23:0] addr;
        acc_size_t   size;
        logic        is_write;
        logic        is_read;
        logic [2:0]  read_len;    // 1 to 4 bytes
        logic [31:0] wdata;
    } mem_req_t;

    // sequencer to read merging, one per completed read beat
    typedef struct packed {
        logic       valid;
        logic       first;        // clears the result
        logic [1:0] dst_byte;     // landing byte of the first taken byte
        logic       take_hi_only;
        logic       take_lo_only;
    } read_beat_t;

    function automatic logic [2:0] size_bytes(acc_size_t s);
        case (s)
            size_byte: return 3'd1;
            size_word: return 3'd2;
            default:   return 3'd4;
        endcase
    endfunction

endpackage

/* hw/mem_read_merge.sv */
//****************************************************************************
// result register that gathers the bytes of read beats
//****************************************************************************
`timescale 1ns/1ps

module mem_read_merge (
    input  logic                clk,
    input  logic                rst,
    input  logic                cen,
    input  mem_pkg::read_beat_t beat,
    input  logic [15:0]         bus_dout,
    output logic [31:0]         mdata
);

    logic [3:0][7:0] nx_data;
    logic [1:0]      dst_hi;   // landing byte of the high lane in a full beat

    assign dst_hi = beat.dst_byte + 2'd1;

    always_comb begin
        nx_data = beat.first ? '0 : mdata;  // unfetched bytes stay zero
        if (beat.take_hi_only) begin
            nx_data[beat.dst_byte] = bus_dout[15:8];
        end else if (beat.take_lo_only) begin
            nx_data[beat.dst_byte] = bus_dout[7:0];
        end else begin
            nx_data[beat.dst_byte] = bus_dout[7:0];
            nx_data[dst_hi]        = bus_dout[15:8];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            mdata <= '0;
        else if (cen && beat.valid)
            mdata <= nx_data;
    end

    a_one_lane: assert property (@(posedge clk) disable iff (rst)
        beat.valid |-> !(beat.take_hi_only && beat.take_lo_only))
        else $error("read beat marks both single lanes");

endmodule

/* hw/mem_unit.sv */
//****************************************************************************
// memory access unit top, address generation, sequencer and read merging
//****************************************************************************
`timescale 1ns/1ps

module mem_unit #(
    parameter int ADDR_W = 24
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 cen,
    // 16-bit bus
    output logic [ADDR_W-1:0]    bus_addr,
    input  logic [15:0]          bus_dout,
    input  logic                 bus_busy,
    output logic [15:0]          bus_din,
    output logic [1:0]           bus_we,
    output logic                 bus_rd,
    // core control
    input  mem_pkg::ea_sel_t     ea_sel,
    input  mem_pkg::acc_size_t   size,
    input  mem_pkg::fetch_mode_t fetch_mode,
    input  logic                 wr,
    input  logic                 inc_pc,   // pc reads wait while high
    input  logic                 da2ea,
    input  logic [31:0]          da,
    input  logic [ADDR_W-1:0]    pc,
    input  logic [31:0]          xsp,
    input  logic [31:0]          md,
    output logic [31:0]          ea,
    output logic [31:0]          mdata,
    output logic                 busy
);

    mem_pkg::mem_req_t   req;
    mem_pkg::read_beat_t beat;
    logic                start;
    logic                pending;
    logic                seq_active;

    assign busy = pending || seq_active;

    mem_addr_gen #(
        .ADDR_W(ADDR_W)
    ) u_addr_gen (
        .clk       (clk),
        .rst       (rst),
        .cen       (cen),
        .ea_sel    (ea_sel),
        .size      (size),
        .fetch_mode(fetch_mode),
        .wr        (wr),
        .inc_pc    (inc_pc),
        .da2ea     (da2ea),
        .da        (da),
        .pc        (pc),
        .xsp       (xsp),
        .md        (md),
        .seq_active(seq_active),
        .req       (req),
        .start     (start),
        .ea        (ea),
        .pending   (pending)
    );

    mem_bus_seq #(
        .ADDR_W(ADDR_W)
    ) u_bus_seq (
        .clk       (clk),
        .rst       (rst),
        .cen       (cen),
        .req       (req),
        .start     (start),
        .bus_busy  (bus_busy),
        .bus_addr  (bus_addr),
        .bus_din   (bus_din),
        .bus_we    (bus_we),
        .bus_rd    (bus_rd),
        .beat      (beat),
        .seq_active(seq_active)
    );

    mem_read_merge u_read_merge (
        .clk     (clk),
        .rst     (rst),
        .cen     (cen),
        .beat    (beat),
        .bus_dout(bus_dout),
        .mdata   (mdata)
    );

endmodule

/* src.f */
hw/mem_pkg.sv
hw/mem_addr_gen.sv
hw/mem_bus_seq.sv
hw/mem_read_merge.sv
hw/mem_unit.sv
verif/mem_bus_model.sv
verif/tb_mem_unit.sv

/* verif/mem_bus_model.sv */
//****************************************************************************
// 16-bit byte-lane memory with random busy and a shadow byte array
//****************************************************************************
`timescale 1ns/1ps

module mem_bus_model #(
    parameter int MEM_AW = 10
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              cen,
    input  logic [23:0]       bus_addr,
    input  logic [15:0]       bus_din,
    input  logic [1:0]        bus_we,
    input  logic              bus_rd,
    output logic [15:0]       bus_dout,
    output logic              bus_busy,
    input  logic              busy_en,   // random wait cycles on
    input  logic [MEM_AW-1:0] chk_addr,
    output logic [7:0]        chk_data,
    output logic [7:0]        chk_exp,
    output logic              shadow_ok
);

    logic [7:0]        mem [2**MEM_AW];
    logic [7:0]        shadow [2**MEM_AW];  // expected contents, kept by the testbench
    logic [MEM_AW-1:0] lo_a;
    logic [MEM_AW-1:0] hi_a;
    logic [31:0]       lfsr;
    logic              b1;
    logic              b2;

    function automatic logic step_bit(inout logic [31:0] s);
        s = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
        return s[0];
    endfunction

    assign lo_a      = {bus_addr[MEM_AW-1:1], 1'b0};
    assign hi_a      = {bus_addr[MEM_AW-1:1], 1'b1};
    assign bus_dout  = {mem[hi_a], mem[lo_a]};
    assign chk_data  = mem[chk_addr];
    assign chk_exp   = shadow[chk_addr];
    assign shadow_ok = chk_data == chk_exp;

    initial begin
        lfsr     = 32'ha7b8_5b1a;
        bus_busy = 1'b0;
        for (int i = 0; i < 2**MEM_AW; i++) begin
            mem[i]    = 8'(i) ^ 8'(i >> 3) ^ 8'h5a;  // every address bit counts
            shadow[i] = 8'(i) ^ 8'(i >> 3) ^ 8'h5a;
        end
    end

    // busy about one cycle in four while a cycle is on the bus
    always @(negedge clk) begin
        if (busy_en && (bus_rd || bus_we != 2'b00)) begin
            b1 = step_bit(lfsr);
            b2 = step_bit(lfsr);
            bus_busy <= b1 && b2;
        end else begin
            bus_busy <= 1'b0;
        end
    end

    always @(posedge clk) begin
        if (!rst && cen && !bus_busy) begin
            if (bus_we[0])
                mem[lo_a] <= bus_din[7:0];
            if (bus_we[1])
                mem[hi_a] <= bus_din[15:8];
        end
    end

endmodule

/* verif/tb_mem_unit.sv */
//****************************************************************************
// testbench for mem_unit, stimulus sequences and checking assertions
//****************************************************************************
`timescale 1ns/1ps

module tb_mem_unit;

    localparam int ADDR_W  = 24;
    localparam int TIMEOUT = 400;

    logic                 clk;
    logic                 rst;
    logic                 cen;
    logic [ADDR_W-1:0]    bus_addr;
    logic [15:0]          bus_dout;
    logic                 bus_busy;
    logic [15:0]          bus_din;
    logic [1:0]           bus_we;
    logic                 bus_rd;
    mem_pkg::ea_sel_t     ea_sel;
    mem_pkg::acc_size_t   size;
    mem_pkg::fetch_mode_t fetch_mode;
    logic                 wr;
    logic                 inc_pc;
    logic                 da2ea;
    logic [31:0]          da;
    logic [ADDR_W-1:0]    pc;
    logic [31:0]          xsp;
    logic [31:0]          md;
    logic [31:0]          ea;
    logic [31:0]          mdata;
    logic                 busy;

    logic                 cen_rand;   // random cen gaps
    logic                 busy_en;
    logic                 chk_en;     // compare model byte with shadow
    logic                 chk_rd;     // compare mdata with exp_mdata
    logic                 no_rd;      // no bus read allowed
    logic [9:0]           chk_addr;
    logic [7:0]           chk_data;
    logic [7:0]           chk_exp;
    logic                 shadow_ok;
    logic [31:0]          exp_mdata;
    logic [31:0]          stim_lfsr;
    logic [31:0]          cen_lfsr;
    logic [ADDR_W-1:0]    a;
    logic [ADDR_W-1:0]    last_addr;
    mem_pkg::acc_size_t   sz;

    mem_unit #(.ADDR_W(ADDR_W)) dut_i (
        .clk(clk), .rst(rst), .cen(cen),
        .bus_addr(bus_addr), .bus_dout(bus_dout), .bus_busy(bus_busy),
        .bus_din(bus_din), .bus_we(bus_we), .bus_rd(bus_rd),
        .ea_sel(ea_sel), .size(size), .fetch_mode(fetch_mode), .wr(wr),
        .inc_pc(inc_pc), .da2ea(da2ea), .da(da), .pc(pc), .xsp(xsp), .md(md),
        .ea(ea), .mdata(mdata), .busy(busy)
    );

    mem_bus_model #(.MEM_AW(10)) model_i (
        .clk(clk), .rst(rst), .cen(cen),
        .bus_addr(bus_addr), .bus_din(bus_din), .bus_we(bus_we), .bus_rd(bus_rd),
        .bus_dout(bus_dout), .bus_busy(bus_busy), .busy_en(busy_en),
        .chk_addr(chk_addr), .chk_data(chk_data), .chk_exp(chk_exp),
        .shadow_ok(shadow_ok)
    );

    function automatic logic step_bit(inout logic [31:0] s);
        s = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
        return s[0];
    endfunction

    function automatic logic [31:0] rand_word(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
            v = {v[30:0], step_bit(stim_lfsr)};
        return v;
    endfunction

    function automatic int size_count(mem_pkg::acc_size_t s);
        case (s)
            mem_pkg::size_byte: return 1;
            mem_pkg::size_word: return 2;
            default:            return 4;
        endcase
    endfunction

    // pc fetches and long mode read four bytes
    function automatic int read_count(mem_pkg::ea_sel_t sel, mem_pkg::acc_size_t s,
                                      mem_pkg::fetch_mode_t fm);
        if (sel == mem_pkg::ea_pc || fm == mem_pkg::fetch_long)
            return 4;
        return size_count(s);
    endfunction

    initial begin
        clk = 1'b0;
    end

    always #20 clk = ~clk;

    always @(negedge clk) begin
        if (cen_rand)
            cen <= step_bit(cen_lfsr) | step_bit(cen_lfsr);
        else
            cen <= 1'b1;
    end

    task automatic wait_idle();
        int n;
        n = 0;
        @(negedge clk);
        while (busy && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (busy) begin
            $display("timeout: busy did not fall within %0d cycles", TIMEOUT);
            $display("Simulation finished: FAIL");
            $fatal(1);
        end
    endtask

    // expected bytes come from the shadow, zero above the read length
    task automatic check_read(logic [ADDR_W-1:0] addr, int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
            v[8*i +: 8] = model_i.shadow[10'(addr + 24'(i))];
        exp_mdata = v;
        chk_rd    = 1'b1;
        @(negedge clk);
        chk_rd = 1'b0;
    endtask

    task automatic do_read(mem_pkg::ea_sel_t sel, logic [ADDR_W-1:0] addr,
                           mem_pkg::acc_size_t s, mem_pkg::fetch_mode_t fm);
        ea_sel     = sel;
        size       = s;
        fetch_mode = fm;
        if (sel == mem_pkg::ea_pc)
            pc = addr;
        else if (sel == mem_pkg::ea_sp)
            xsp = 32'(addr);
        else
            da = 32'(addr);
        wait_idle();
        check_read(addr, read_count(sel, s, fm));
        last_addr = addr;
    endtask

    // write, sweep the bytes around it, then read it back
    task automatic do_write(logic [ADDR_W-1:0] addr, mem_pkg::acc_size_t s,
                            logic [31:0] data);
        int n;
        n      = size_count(s);
        ea_sel = mem_pkg::ea_da;
        da     = 32'(addr);
        size   = s;
        md     = data;
        wr     = 1'b1;
        for (int i = 0; i < n; i++)
            model_i.shadow[10'(addr + 24'(i))] = data[8*i +: 8];
        wait_idle();
        for (int k = 0; k < 6; k++) begin
            chk_addr = 10'(addr + 24'(k) - 24'd1);
            chk_en   = 1'b1;
            @(negedge clk);
        end
        chk_en = 1'b0;
        wr     = 1'b0;   // cached address was dropped, so this reads again
        wait_idle();
        check_read(addr, read_count(mem_pkg::ea_da, s, fetch_mode));
        last_addr = addr;
    endtask

    a_reset_idle: assert property (@(posedge clk) rst |-> !bus_rd && bus_we == 2'b00)
        else begin
            $display("bus strobes active during reset");
            $display("Simulation finished: FAIL");
            $fatal(1);
        end

    a_read_data: assert property (@(posedge clk) chk_rd |-> mdata == exp_mdata)
        else begin
            $display("[FAIL] %0t mdata %h, expected %h", $time, mdata, exp_mdata);
            $display("Simulation finished: FAIL");
            $fatal(1);
        end

    a_mem_byte: assert property (@(posedge clk) chk_en |-> shadow_ok)
        else begin
            $display("[FAIL] %0t memory byte %h is %h, expected %h",
                     $time, chk_addr, chk_data, chk_exp);
            $display("Simulation finished: FAIL");
            $fatal(1);
        end

    a_cache_hit: assert property (@(posedge clk) no_rd |-> !bus_rd && !busy)
        else begin
            $display("[FAIL] %0t bus read started where none was due", $time);
            $display("Simulation finished: FAIL");
            $fatal(1);
        end

    a_ea_load: assert property (@(posedge clk) disable iff (rst)
        cen && da2ea |=> ea == $past(da))
        else begin
            $display("[FAIL] %0t ea is %h, expected %h", $time, ea, $past(da));
            $display("Simulation finished: FAIL");
            $fatal(1);
        end

    initial begin
        rst        = 1'b1;
        cen        = 1'b1;
        ea_sel     = mem_pkg::ea_pc;
        size       = mem_pkg::size_byte;
        fetch_mode = mem_pkg::fetch_sized;
        wr         = 1'b0;
        inc_pc     = 1'b0;
        da2ea      = 1'b0;
        da         = '0;
        pc         = '0;
        xsp        = '0;
        md         = '0;
        cen_rand   = 1'b0;
        busy_en    = 1'b0;
        chk_en     = 1'b0;
        chk_rd     = 1'b0;
        no_rd      = 1'b0;
        chk_addr   = '0;
        exp_mdata  = '0;
        stim_lfsr  = 32'ha7b8_5b1a;
        cen_lfsr   = 32'ha7b8_5b1a;
        last_addr  = '0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        wait_idle();   // pc fetch at address zero

        // writes of every size at even and odd start
        for (int s = 0; s < 3; s++)
            for (int off = 0; off < 2; off++)
                do_write(24'h040 + 24'(s * 16 + off), mem_pkg::acc_size_t'(2'(s)),
                         rand_word(32));

        for (int s = 0; s < 3; s++)
            for (int off = 0; off < 2; off++)
                do_read(mem_pkg::ea_da, 24'h080 + 24'(s * 8 + off),
                        mem_pkg::acc_size_t'(2'(s)), mem_pkg::fetch_sized);

        do_read(mem_pkg::ea_da, 24'h0c1, mem_pkg::size_byte, mem_pkg::fetch_long);
        do_read(mem_pkg::ea_da, 24'h0c4, mem_pkg::size_word, mem_pkg::fetch_long);
        // write over the cached address so the read back needs the bus
        do_write(24'h0c4, mem_pkg::size_word, 32'h0000_3c96);
        do_read(mem_pkg::ea_pc, 24'h0d3, mem_pkg::size_byte, mem_pkg::fetch_sized);

        // same address through another source hits the cache
        do_read(mem_pkg::ea_da, 24'h0e5, mem_pkg::size_word, mem_pkg::fetch_sized);
        ea_sel = mem_pkg::ea_sp;
        xsp    = 32'h0e5;
        size   = mem_pkg::size_long;
        no_rd  = 1'b1;
        repeat (6) @(negedge clk);
        no_rd = 1'b0;

        // pc read held off by inc_pc
        ea_sel = mem_pkg::ea_pc;
        pc     = 24'h0f1;
        inc_pc = 1'b1;
        no_rd  = 1'b1;
        repeat (6) @(negedge clk);
        no_rd  = 1'b0;
        inc_pc = 1'b0;
        wait_idle();
        check_read(24'h0f1, 4);

        // ea register load, then an ea_mem read
        da    = 32'h123;
        da2ea = 1'b1;
        @(negedge clk);
        da2ea      = 1'b0;
        da         = 32'h2c6;   // da moves on, the read must follow ea
        ea_sel     = mem_pkg::ea_mem;
        size       = mem_pkg::size_long;
        fetch_mode = mem_pkg::fetch_sized;
        wait_idle();
        check_read(24'h123, 4);
        last_addr = 24'h123;

        // random traffic with bus wait cycles and cen gaps
        cen_rand = 1'b1;
        busy_en  = 1'b1;
        for (int t = 0; t < 12; t++) begin
            a  = 24'(rand_word(9)) + 24'h080;
            sz = mem_pkg::acc_size_t'(2'(rand_word(2) % 3));
            do_write(a, sz, rand_word(32));
            a = 24'(rand_word(9)) + 24'h080;
            if (a == last_addr)
                a = a + 24'd8;
            sz = mem_pkg::acc_size_t'(2'(rand_word(2) % 3));
            do_read(mem_pkg::ea_da, a, sz, mem_pkg::fetch_mode_t'(1'(rand_word(1))));
        end
        cen_rand = 1'b0;
        busy_en  = 1'b0;
        repeat (2) @(negedge clk);

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule
